/* include/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// FIFO geometry
`define UART_FIFO_WORDS     32
`define UART_FIFO_ADR       5       // Pointer width, word count is one bit wider

// Data and bus widths
`define UART_DATA_W         8
`define UART_BUS_DW         32
`define UART_BUS_AW         4

// Clocks per bit minus one
`define UART_BEAT           15

// Control register bits
`define UART_CTL_RUN        0

// Status register bit positions
`define UART_STA_TX_EP      0
`define UART_STA_TX_FL      1
`define UART_STA_TX_WRDS    2       // 6 bit field
`define UART_STA_RX_EP      8
`define UART_STA_RX_FL      9
`define UART_STA_RX_WRDS    10      // 6 bit field

`endif

/* source/uart_pkg.sv */
`include "uart_defines.svh"

package uart_pkg;

    // Local bus request
    typedef struct packed {
        logic [`UART_BUS_AW-1:0]    adr;
        logic                       wr;
        logic                       rd;
        logic [`UART_BUS_DW-1:0]    din;
    } bus_req_t;

    // Local bus response
    typedef struct packed {
        logic [`UART_BUS_DW-1:0]    dout;
        logic                       vld;
    } bus_rsp_t;

    // FIFO fill state as seen by the status register
    typedef struct packed {
        logic                       ep;     // Empty
        logic                       fl;     // Full
        logic [`UART_FIFO_ADR:0]    wrds;   // Used words
    } fifo_status_t;

    typedef enum logic [`UART_BUS_AW-1:0] {
        REG_CTL = 4'd0,
        REG_STA = 4'd1,
        REG_TXD = 4'd2,
        REG_RXD = 4'd3
    } reg_addr_e;

    // Shared by both serial engines
    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } uart_state_e;

endpackage

/* source/uart_fifo.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_fifo
    import uart_pkg::*;
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  logic                        clr,
    input  logic                        wr,
    input  logic                        rd,
    input  logic [`UART_DATA_W-1:0]     din,
    output logic [`UART_DATA_W-1:0]     dout,
    output fifo_status_t                status
);

    logic [`UART_DATA_W-1:0]    mem [`UART_FIFO_WORDS];
    logic [`UART_FIFO_ADR-1:0]  wp;
    logic [`UART_FIFO_ADR-1:0]  rp;
    logic [`UART_FIFO_ADR:0]    cnt;
    logic                       ep;
    logic                       fl;
    logic                       we;
    logic                       re;

    assign ep = (cnt == 0);
    assign fl = (cnt == `UART_FIFO_WORDS);

    // Full writes and empty reads are dropped
    assign we = wr && !fl;
    assign re = rd && !ep;

    // Storage
    always_ff @(posedge CLK_IN)
    begin
        if (we)
            mem[wp] <= din;
    end

    // Pointers and word count
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            wp  <= '0;
            rp  <= '0;
            cnt <= '0;
        end
        else if (clr)
        begin
            wp  <= '0;
            rp  <= '0;
            cnt <= '0;
        end
        else
        begin
            if (we)
                wp <= wp + 1'b1;    // Wraps at depth
            if (re)
                rp <= rp + 1'b1;

            if (we && !re)
                cnt <= cnt + 1'b1;
            else if (re && !we)
                cnt <= cnt - 1'b1;
        end
    end

    assign dout = mem[rp];  // Show-ahead head

    assign status.ep   = ep;
    assign status.fl   = fl;
    assign status.wrds = cnt;

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  logic                        run,
    input  logic [`UART_DATA_W-1:0]     fifo_dout,
    input  logic                        fifo_ep,
    output logic                        fifo_rd,
    output logic                        tx_line
);

    uart_state_e                sm_cur;
    uart_state_e                sm_nxt;
    logic [15:0]                beat_cnt;
    logic                       beat_end;
    logic                       beat_end_q;
    logic                       beat;
    logic [3:0]                 bit_cnt;
    logic                       bit_cnt_end;
    logic                       bit_cnt_ld;
    logic                       bit_cnt_dec;
    logic [`UART_DATA_W:0]      shft;   // Data plus start bit
    logic                       shft_ld;
    logic                       shft_nxt;

    // Beat generator, free running while enabled
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            beat_cnt <= '0;
        else if (!run)
            beat_cnt <= '0;
        else if (beat_end)
            beat_cnt <= 16'(`UART_BEAT);
        else
            beat_cnt <= beat_cnt - 1'b1;
    end

    assign beat_end = (beat_cnt == 0);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            beat_end_q <= 1'b1;
        else
            beat_end_q <= beat_end;
    end

    assign beat = run && beat_end && !beat_end_q;   // One clock per bit period

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            sm_cur <= ST_IDLE;
        else if (run)
            sm_cur <= sm_nxt;
        else
            sm_cur <= ST_IDLE;
    end

    always_comb
    begin
        sm_nxt      = sm_cur;
        fifo_rd     = 1'b0;
        shft_ld     = 1'b0;
        shft_nxt    = 1'b0;
        bit_cnt_ld  = 1'b0;
        bit_cnt_dec = 1'b0;

        unique case (sm_cur)
            ST_IDLE:
            begin
                // Start a frame on a beat when data is waiting
                if (beat && !fifo_ep)
                begin
                    fifo_rd    = 1'b1;
                    shft_ld    = 1'b1;
                    bit_cnt_ld = 1'b1;
                    sm_nxt     = ST_SHIFT;
                end
            end

            ST_SHIFT:
            begin
                if (beat)
                begin
                    if (bit_cnt_end)
                        sm_nxt = ST_IDLE;   // Stop bit stays on the line
                    else
                    begin
                        shft_nxt    = 1'b1;
                        bit_cnt_dec = 1'b1;
                    end
                end
            end

            default:
                sm_nxt = ST_IDLE;
        endcase
    end

    // Bits remaining after the start bit
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            bit_cnt <= '0;
        else if (bit_cnt_ld)
            bit_cnt <= 4'd9;
        else if (bit_cnt_dec)
            bit_cnt <= bit_cnt - 1'b1;
    end

    assign bit_cnt_end = (bit_cnt == 0);

    // Ones shift in behind the data and form the stop bit
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            shft <= '1;
        else if (!run)
            shft <= '1;
        else if (shft_ld)
            shft <= {fifo_dout, 1'b0};
        else if (shft_nxt)
            shft <= {1'b1, shft[`UART_DATA_W:1]};
    end

    // Line register, idles high
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            tx_line <= 1'b1;
        else if (!run)
            tx_line <= 1'b1;
        else
            tx_line <= shft[0];
    end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  logic                        run,
    input  logic                        rx_line,
    output logic                        fifo_wr,
    output logic [`UART_DATA_W-1:0]     fifo_din
);

    uart_state_e                sm_cur;
    uart_state_e                sm_nxt;
    logic                       rx_q;
    logic                       rx_qq;
    logic                       str;
    logic                       beat_ld;
    logic                       beat_act;
    logic [15:0]                beat_cnt;
    logic                       beat_end;
    logic                       beat_end_q;
    logic                       beat;
    logic [3:0]                 bit_cnt;
    logic                       bit_cnt_end;
    logic                       bit_cnt_ld;
    logic                       bit_cnt_dec;
    logic [`UART_DATA_W-1:0]    shft;
    logic                       shft_nxt;

    // Line register plus one stage for the edge detector
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            rx_q  <= 1'b1;
            rx_qq <= 1'b1;
        end
        else
        begin
            rx_q  <= rx_line;
            rx_qq <= rx_q;
        end
    end

    assign str = rx_qq && !rx_q;    // Falling edge

    // Beat counter only runs inside a frame
    assign beat_act = run && (sm_nxt == ST_SHIFT);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            beat_cnt <= '0;
        else if (!beat_act)
            beat_cnt <= '0;
        else if (beat_ld)
            beat_cnt <= 16'(`UART_BEAT / 2);   // Mid-bit alignment
        else if (beat_end)
            beat_cnt <= 16'(`UART_BEAT);
        else
            beat_cnt <= beat_cnt - 1'b1;
    end

    assign beat_end = (beat_cnt == 0);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            beat_end_q <= 1'b1;
        else
            beat_end_q <= beat_end;
    end

    assign beat = beat_end && !beat_end_q;

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            sm_cur <= ST_IDLE;
        else if (run)
            sm_cur <= sm_nxt;
        else
            sm_cur <= ST_IDLE;
    end

    always_comb
    begin
        sm_nxt      = sm_cur;
        beat_ld     = 1'b0;
        fifo_wr     = 1'b0;
        shft_nxt    = 1'b0;
        bit_cnt_ld  = 1'b0;
        bit_cnt_dec = 1'b0;

        unique case (sm_cur)
            ST_IDLE:
            begin
                if (str)
                begin
                    beat_ld    = 1'b1;
                    bit_cnt_ld = 1'b1;
                    sm_nxt     = ST_SHIFT;
                end
            end

            ST_SHIFT:
            begin
                if (beat)
                begin
                    // Tenth beat lands in the stop bit, which is not checked
                    if (bit_cnt_end)
                    begin
                        fifo_wr = 1'b1;
                        sm_nxt  = ST_IDLE;
                    end
                    else
                    begin
                        shft_nxt    = 1'b1;
                        bit_cnt_dec = 1'b1;
                    end
                end
            end

            default:
                sm_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            bit_cnt <= '0;
        else if (bit_cnt_ld)
            bit_cnt <= 4'd9;
        else if (bit_cnt_dec)
            bit_cnt <= bit_cnt - 1'b1;
    end

    assign bit_cnt_end = (bit_cnt == 0);

    // Start bit falls out the bottom after nine samples
    always_ff @(posedge CLK_IN)
    begin
        if (shft_nxt)
            shft <= {rx_q, shft[`UART_DATA_W-1:1]};
    end

    assign fifo_din = shft;

endmodule

/* source/uart_regs.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_regs
    import uart_pkg::*;
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  bus_req_t                    bus_req,
    output bus_rsp_t                    bus_rsp,
    output logic                        run,
    output logic                        tx_wr,
    output logic [`UART_DATA_W-1:0]     tx_din,
    output logic                        rx_rd,
    input  fifo_status_t                tx_status,
    input  fifo_status_t                rx_status,
    input  logic [`UART_DATA_W-1:0]     rx_dout
);

    bus_req_t                   req_q;
    reg_addr_e                  adr_sel;
    logic                       rd_q;
    logic [`UART_BUS_DW-1:0]    sta;
    logic [`UART_BUS_DW-1:0]    dout;

    // Bus input registers
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            req_q <= '0;
        else
            req_q <= bus_req;
    end

    assign adr_sel = reg_addr_e'(req_q.adr);

    // Control register
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            run <= 1'b0;
        else if (req_q.wr && adr_sel == REG_CTL)
            run <= req_q.din[`UART_CTL_RUN];
    end

    // Status word from both FIFOs
    always_comb
    begin
        sta = '0;
        sta[`UART_STA_TX_EP] = tx_status.ep;
        sta[`UART_STA_TX_FL] = tx_status.fl;
        sta[`UART_STA_TX_WRDS +: `UART_FIFO_ADR+1] = tx_status.wrds;
        sta[`UART_STA_RX_EP] = rx_status.ep;
        sta[`UART_STA_RX_FL] = rx_status.fl;
        sta[`UART_STA_RX_WRDS +: `UART_FIFO_ADR+1] = rx_status.wrds;
    end

    // Read multiplexer
    always_comb
    begin
        dout = '0;
        unique case (adr_sel)
            REG_CTL: dout[`UART_CTL_RUN] = run;
            REG_STA: dout = sta;
            REG_RXD: dout[`UART_DATA_W-1:0] = rx_dout;  // Head before the pop
            default: dout = '0;
        endcase
    end

    assign bus_rsp.dout = dout;
    assign bus_rsp.vld  = req_q.rd;     // Echo of the registered read

    // Previous read level for the pop edge
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            rd_q <= 1'b0;
        else
            rd_q <= req_q.rd;
    end

    assign rx_rd  = req_q.rd && !rd_q && (adr_sel == REG_RXD);
    assign tx_wr  = req_q.wr && (adr_sel == REG_TXD);
    assign tx_din = req_q.din[`UART_DATA_W-1:0];

endmodule

/* source/uart_top.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top
    import uart_pkg::*;
(
    input  logic        CLK_IN,
    input  logic        RST_IN,
    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,
    input  logic        uart_rx_in,
    output logic        uart_tx_out
);

    logic                       run;
    logic                       tx_wr;
    logic [`UART_DATA_W-1:0]    tx_din;
    logic                       tx_rd;
    logic [`UART_DATA_W-1:0]    tx_dout;
    fifo_status_t               tx_status;
    logic                       rx_wr;
    logic [`UART_DATA_W-1:0]    rx_din;
    logic                       rx_rd;
    logic [`UART_DATA_W-1:0]    rx_dout;
    fifo_status_t               rx_status;

    uart_regs i_uart_regs
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .run        (run),
        .tx_wr      (tx_wr),
        .tx_din     (tx_din),
        .rx_rd      (rx_rd),
        .tx_status  (tx_status),
        .rx_status  (rx_status),
        .rx_dout    (rx_dout)
    );

    // Both FIFOs flush while stopped
    uart_fifo tx_fifo
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .clr        (~run),
        .wr         (tx_wr),
        .rd         (tx_rd),
        .din        (tx_din),
        .dout       (tx_dout),
        .status     (tx_status)
    );

    uart_fifo rx_fifo
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .clr        (~run),
        .wr         (rx_wr),
        .rd         (rx_rd),
        .din        (rx_din),
        .dout       (rx_dout),
        .status     (rx_status)
    );

    uart_tx i_uart_tx
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .run        (run),
        .fifo_dout  (tx_dout),
        .fifo_ep    (tx_status.ep),
        .fifo_rd    (tx_rd),
        .tx_line    (uart_tx_out)
    );

    uart_rx i_uart_rx
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .run        (run),
        .rx_line    (uart_rx_in),
        .fifo_wr    (rx_wr),
        .fifo_din   (rx_din)
    );

endmodule

/* sim/uart_properties.sv */
`timescale 1ns/1ps

module uart_properties
    import uart_pkg::*;
(
    input  logic            CLK_IN,
    input  logic            RST_IN,
    input  bus_req_t        bus_req,
    input  bus_rsp_t        bus_rsp,
    input  logic            run,
    input  logic            tx_rd,
    input  fifo_status_t    tx_status,
    input  logic            uart_tx_out
);

    // Response valid exactly one cycle after the read strobe
    vld_follows_rd: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        bus_rsp.vld == $past(bus_req.rd))
        else $error("bus vld does not match the read strobe of the previous cycle");

    tx_pop_not_empty: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        tx_rd |-> !tx_status.ep)
        else $error("transmit FIFO popped while empty");

    // Line register follows run one clock later
    tx_idle_when_stopped: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        !run |=> uart_tx_out)
        else $error("uart_tx_out low while run is clear");

endmodule

/* sim/uart_tb.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb
    import uart_pkg::*;
();

    localparam int BIT_CLKS    = `UART_BEAT + 1;
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;
    localparam int START_MAX   = 4 * FRAME_CLKS;    // Clocks to wait for a start bit
    localparam int POLL_MAX    = 2 * FRAME_CLKS;    // Status polls before giving up
    localparam int TX_BYTES    = 20;

    logic           CLK_IN;
    logic           RST_IN;
    bus_req_t       bus_req;
    bus_rsp_t       bus_rsp;
    logic           uart_rx_in;
    logic           uart_tx_out;

    int             err_cnt;
    int             tmo_cnt;
    logic [31:0]    rnd_state;
    logic [7:0]     tx_exp_q[$];
    logic [7:0]     rx_exp_q[$];
    logic [7:0]     tx_bytes[TX_BYTES];

    uart_top i_uart_top
    (
        .CLK_IN         (CLK_IN),
        .RST_IN         (RST_IN),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .uart_rx_in     (uart_rx_in),
        .uart_tx_out    (uart_tx_out)
    );

    bind uart_top uart_properties i_uart_properties
    (
        .CLK_IN         (CLK_IN),
        .RST_IN         (RST_IN),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .run            (run),
        .tx_rd          (tx_rd),
        .tx_status      (tx_status),
        .uart_tx_out    (uart_tx_out)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever #5 CLK_IN = ~CLK_IN;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        rnd_state = xorshift32(rnd_state);
        b = rnd_state[7:0];
    endtask

    // Expected status word from FIFO fill levels
    function automatic logic [31:0] status_word(input int tx_n, input int rx_n);
        logic [31:0] s;
        s = '0;
        s[`UART_STA_TX_EP] = (tx_n == 0);
        s[`UART_STA_TX_FL] = (tx_n == `UART_FIFO_WORDS);
        s[`UART_STA_TX_WRDS +: 6] = 6'(tx_n);
        s[`UART_STA_RX_EP] = (rx_n == 0);
        s[`UART_STA_RX_FL] = (rx_n == `UART_FIFO_WORDS);
        s[`UART_STA_RX_WRDS +: 6] = 6'(rx_n);
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        err_cnt++;
    endtask

    task automatic bus_write(input reg_addr_e adr, input logic [31:0] data);
        @(negedge CLK_IN);
        bus_req.adr = adr;
        bus_req.din = data;
        bus_req.wr  = 1'b1;
        @(negedge CLK_IN);
        bus_req.wr  = 1'b0;
    endtask

    // Response is sampled mid-cycle after the request edge
    task automatic bus_read(input reg_addr_e adr, output logic [31:0] data);
        @(negedge CLK_IN);
        bus_req.adr = adr;
        bus_req.rd  = 1'b1;
        @(negedge CLK_IN);
        bus_req.rd  = 1'b0;
        data = bus_rsp.dout;
        if (bus_rsp.vld !== 1'b1)
            report_mismatch("bus_vld", 32'h1, {31'h0, bus_rsp.vld});
    endtask

    task automatic check_status(input string name, input int tx_n, input int rx_n);
        logic [31:0] sta;
        logic [31:0] exp_w;
        exp_w = status_word(tx_n, rx_n);
        bus_read(REG_STA, sta);
        if (sta !== exp_w)
            report_mismatch(name, exp_w, sta);
    endtask

    // 8N1 frame with LSB first
    task automatic serial_send(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(negedge CLK_IN);
            uart_rx_in = frame[i];
            repeat (BIT_CLKS - 1) @(negedge CLK_IN);
        end
    endtask

    task automatic serial_receive(output logic [7:0] data, output logic ok);
        int n;
        n = 0;
        ok = 1'b0;
        data = '0;
        while (uart_tx_out !== 1'b0 && n < START_MAX)
        begin
            @(negedge CLK_IN);
            n++;
        end
        if (uart_tx_out !== 1'b0)
        begin
            $display("Timed out waiting for a start bit on uart_tx_out");
            tmo_cnt++;
        end
        else
        begin
            repeat (BIT_CLKS / 2) @(negedge CLK_IN);   // Mid start bit
            if (uart_tx_out !== 1'b0)
                report_mismatch("tx_start_bit", 32'h0, {31'h0, uart_tx_out});
            for (int i = 0; i < 8; i++)
            begin
                repeat (BIT_CLKS) @(negedge CLK_IN);
                data[i] = uart_tx_out;
            end
            repeat (BIT_CLKS) @(negedge CLK_IN);
            if (uart_tx_out !== 1'b1)
                report_mismatch("tx_stop_bit", 32'h1, {31'h0, uart_tx_out});
            ok = 1'b1;
        end
    endtask

    task automatic send_frames(input int n);
        logic [7:0] b;
        for (int i = 0; i < n; i++)
        begin
            draw_byte(b);
            serial_send(b);
            if (rx_exp_q.size() < `UART_FIFO_WORDS)
                rx_exp_q.push_back(b);  // Full FIFO drops the byte
        end
    endtask

    task automatic wait_rx_words(input int n);
        logic [31:0] sta;
        int polls;
        polls = 0;
        bus_read(REG_STA, sta);
        while (sta[`UART_STA_RX_WRDS +: 6] != n && polls < POLL_MAX)
        begin
            bus_read(REG_STA, sta);
            polls++;
        end
        if (sta[`UART_STA_RX_WRDS +: 6] != n)
        begin
            $display("Timed out waiting for %0d bytes in the receive FIFO", n);
            tmo_cnt++;
        end
    endtask

    // Drains the receive FIFO against the model
    task automatic read_rx_bytes(input string name);
        logic [31:0] data;
        logic [7:0] exp_b;
        while (rx_exp_q.size() > 0)
        begin
            exp_b = rx_exp_q.pop_front();
            bus_read(REG_RXD, data);
            if (data !== {24'h0, exp_b})
                report_mismatch(name, {24'h0, exp_b}, data);
        end
    endtask

    initial
    begin
        logic [31:0] rd_data;
        logic [7:0] got;
        logic [7:0] exp_b;
        logic [7:0] tx_b;
        logic ok;

        RST_IN     = 1'b1;
        bus_req    = '0;
        uart_rx_in = 1'b1;
        err_cnt    = 0;
        tmo_cnt    = 0;
        rnd_state  = 32'd45592;

        repeat (5) @(posedge CLK_IN);
        @(negedge CLK_IN);
        RST_IN = 1'b0;

        // Reset values
        bus_read(REG_CTL, rd_data);
        if (rd_data !== 32'h0)
            report_mismatch("reset_ctl", 32'h0, rd_data);
        check_status("reset_sta", 0, 0);
        if (uart_tx_out !== 1'b1)
            report_mismatch("reset_tx_line", 32'h1, {31'h0, uart_tx_out});

        // Transmit path
        bus_write(REG_CTL, 32'h1);
        for (int i = 0; i < TX_BYTES; i++)
        begin
            draw_byte(tx_bytes[i]);
            tx_exp_q.push_back(tx_bytes[i]);
        end
        fork
            begin
                for (int i = 0; i < TX_BYTES; i++)
                    bus_write(REG_TXD, {24'h0, tx_bytes[i]});
            end
            begin
                for (int i = 0; i < TX_BYTES; i++)
                begin
                    serial_receive(got, ok);
                    if (ok)
                    begin
                        exp_b = tx_exp_q.pop_front();
                        if (got !== exp_b)
                            report_mismatch("tx_frame", {24'h0, exp_b}, {24'h0, got});
                    end
                end
            end
        join
        tx_exp_q.delete();
        check_status("tx_done_sta", 0, 0);

        // Receive path
        send_frames(20);
        wait_rx_words(20);
        read_rx_bytes("rx_data");

        // Overflow drops the 33rd byte
        send_frames(33);
        wait_rx_words(32);
        check_status("rx_full_sta", 0, `UART_FIFO_WORDS);
        read_rx_bytes("rx_full_data");
        check_status("rx_drained_sta", 0, 0);

        // Stop flushes both FIFOs
        send_frames(3);
        wait_rx_words(3);
        for (int i = 0; i < 3; i++)
        begin
            draw_byte(tx_b);
            bus_write(REG_TXD, {24'h0, tx_b});    // Only one leaves before the stop
        end
        bus_write(REG_CTL, 32'h0);
        rx_exp_q.delete();
        bus_read(REG_CTL, rd_data);
        if (rd_data !== 32'h0)
            report_mismatch("stop_ctl", 32'h0, rd_data);
        check_status("stop_sta", 0, 0);

        bus_write(REG_CTL, 32'h1);
        send_frames(4);
        wait_rx_words(4);
        read_rx_bytes("rerun_data");
        check_status("rerun_sta", 0, 0);

        $display("Errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_top.sv
sim/uart_properties.sv
sim/uart_tb.sv

/* Bender.yml */
package:
  name: uart_periph

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/uart_pkg.sv
      - source/uart_fifo.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/uart_regs.sv
      - source/uart_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/uart_properties.sv
      - sim/uart_tb.sv
